// File: list.f
+incdir+source
source/stage3_pkg.sv
source/mw_control.sv
source/dmem_access.sv
source/data_ram.sv
source/stage3.sv
source/mem_stage_top.sv
verif/tb_mem_stage.sv

// File: Makefile
# Verilator flow for the memory/writeback stage testbench
TOP       ?= tb_mem_stage
FILELIST  ?= list.f
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --sv --timing --top-module $(TOP)

FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

# the log decides the result, the exit code of the binary is not trusted
sim: build
	-./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "no result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_mem_stage.sv
// self-checking testbench for mem_stage_top; halfword accesses are only driven at aligned offsets
`default_nettype none
`include "stage3_config.svh"

module tb_mem_stage import stage3_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // byte addresses that stay inside the RAM
    localparam logic [31:0] ADDR_MASK = `DRAM_WORDS * 4 - 1;
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic [31:0] pc;
    logic [31:0] alu_out;
    logic [31:0] rs2d;
    logic [31:0] inst;
    logic [31:0] wb_data;
    logic [4:0]  wb_rd;
    logic        rwe;

    integer      seed = 32'h7a2;
    int          cycles = 0;
    // shadow copy of the data RAM
    logic [31:0] shadow [`DRAM_WORDS];
    logic [31:0] addrs [40];
    // expectations are packed as {rwe, rd, wb_data}
    logic [37:0] last_exp;
    logic [37:0] pend_exp;
    logic        pend_valid = 1'b0;
    logic [37:0] chk_exp;
    logic        chk_valid = 1'b0;

    mem_stage_top u_mem_stage_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .pc      (pc),
        .alu_out (alu_out),
        .rs2d    (rs2d),
        .inst    (inst),
        .wb_data (wb_data),
        .wb_rd   (wb_rd),
        .rwe     (rwe)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got);
        if (got !== exp_v) begin
            $display("Mismatch %s expected 0x%08h got 0x%08h", name, exp_v, got);
            $display("Simulation finished: FAIL");
            $fatal(1, "first error");
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // opcode, rd and funct3 in their RV32I positions with fixed upper bits
    function automatic logic [31:0] make_inst(input opcode_e op, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {17'h0a5a5, f3, rd, op};
    endfunction

    // expected {rwe, rd, wb_data} one cycle after the instruction is accepted
    function automatic logic [37:0] expect_wb(input logic [31:0] i, input logic [31:0] p,
                                              input logic [31:0] a);
        logic [31:0] word;
        logic [4:0]  sh;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] data;
        logic        we;
        word = shadow[a[`DRAM_AW+1:2]];
        sh   = {a[1:0], 3'b000};
        b    = word[sh +: 8];
        h    = sh[4] ? word[31:16] : word[15:0];
        data = a;
        we   = 1'b0;
        case (i[6:0])
            OPC_LOAD: begin
                we = 1'b1;
                case (i[14:12])
                    FNC_LB:  data = {{24{b[7]}}, b};
                    FNC_LBU: data = {24'd0, b};
                    FNC_LH:  data = {{16{h[15]}}, h};
                    FNC_LHU: data = {16'd0, h};
                    default: data = word;
                endcase
            end
            OPC_JAL, OPC_JALR: begin
                we   = 1'b1;
                data = p + 32'd4;
            end
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: we = 1'b1;
            // stores and branches write no register
            default: we = 1'b0;
        endcase
        return {we, i[11:7], data};
    endfunction

    task automatic update_shadow(input logic [31:0] i, input logic [31:0] a,
                                 input logic [31:0] d);
        logic [`DRAM_AW-1:0] idx;
        idx = a[`DRAM_AW+1:2];
        if (i[6:0] == OPC_STORE) begin
            case (i[14:12])
                FNC_SB: shadow[idx][{a[1:0], 3'b000} +: 8] = d[7:0];
                FNC_SH: begin
                    if (a[1]) shadow[idx][31:16] = d[15:0];
                    else shadow[idx][15:0] = d[15:0];
                end
                FNC_SW:  shadow[idx] = d;
                default: ;
            endcase
        end
    endtask

    // one cycle of stimulus on the falling edge
    task automatic send(input logic [31:0] i, input logic [31:0] p, input logic [31:0] a,
                        input logic [31:0] d, input logic s, input logic chk);
        @(negedge clk);
        inst    = i;
        pc      = p;
        alu_out = a;
        rs2d    = d;
        stall   = s;
        // stalled cycle leaves memory and outputs as they were
        if (!s) begin
            last_exp = expect_wb(i, p, a);
            update_shadow(i, a, d);
        end
        pend_exp   = last_exp;
        pend_valid = chk;
    endtask

    task automatic run_inst(input logic [31:0] i, input logic [31:0] a, input logic [31:0] d);
        send(i, next_rand() & 32'hffff_fffc, a, d, 1'b0, 1'b1);
    endtask

    // one-deep expectation pipeline moved at the capturing edge
    always @(posedge clk) begin
        chk_exp   <= pend_exp;
        chk_valid <= pend_valid;
    end

    // mid-cycle compare against the instruction accepted at the last posedge
    always @(negedge clk) begin
        if (chk_valid) begin
            check_val("rwe", {31'd0, chk_exp[37]}, {31'd0, rwe});
            check_val("wb_rd", {27'd0, chk_exp[36:32]}, {27'd0, wb_rd});
            if (chk_exp[37]) begin
                check_val("wb_data", chk_exp[31:0], wb_data);
            end
        end
    end

    initial begin
        logic [31:0] base;
        logic [31:0] idle;
        idle       = make_inst(OPC_BRANCH, 3'b000, 5'd0);
        rst_n      = 1'b0;
        stall      = 1'b0;
        pc         = 32'd0;
        alu_out    = 32'd0;
        rs2d       = 32'd0;
        inst       = idle;
        pend_exp   = '0;
        last_exp   = '0;

        // reset for 8 cycles and one more cycle with a branch in flight
        for (int c = 0; c < 9; c++) begin
            @(negedge clk);
            check_val("rwe", 32'd0, {31'd0, rwe});
            check_val("wb_rd", 32'd0, {27'd0, wb_rd});
            if (c == 7) rst_n = 1'b1;
        end

        // ALU and jump writeback
        run_inst(make_inst(OPC_OP, 3'b000, 5'd5), next_rand(), next_rand());
        run_inst(make_inst(OPC_OP_IMM, 3'b000, 5'd6), next_rand(), next_rand());
        run_inst(make_inst(OPC_LUI, 3'b000, 5'd7), next_rand(), next_rand());
        run_inst(make_inst(OPC_AUIPC, 3'b000, 5'd9), next_rand(), next_rand());
        run_inst(make_inst(OPC_JAL, 3'b000, 5'd1), next_rand(), next_rand());
        run_inst(make_inst(OPC_JALR, 3'b000, 5'd3), next_rand(), next_rand());

        // word stores, a branch, then word loads back
        for (int k = 0; k < 40; k++) begin
            addrs[k] = next_rand() & ADDR_MASK & 32'hffff_fffc;
            run_inst(make_inst(OPC_STORE, FNC_SW, 5'(k)), addrs[k], next_rand());
        end
        run_inst(make_inst(OPC_BRANCH, 3'b001, 5'd4), next_rand(), next_rand());
        for (int k = 0; k < 40; k++) begin
            run_inst(make_inst(OPC_LOAD, FNC_LW, 5'(k)), addrs[k], next_rand());
        end

        // sub-word stores into a known word followed by extended loads
        for (int w = 0; w < 4; w++) begin
            base = next_rand() & ADDR_MASK & 32'hffff_fffc;
            run_inst(make_inst(OPC_STORE, FNC_SW, 5'd0), base, next_rand());
            for (int off = 0; off < 4; off++) begin
                run_inst(make_inst(OPC_STORE, FNC_SB, 5'd0), base + 32'(off), next_rand());
                run_inst(make_inst(OPC_LOAD, FNC_LB, 5'd13), base + 32'(off), next_rand());
                run_inst(make_inst(OPC_LOAD, FNC_LBU, 5'd14), base + 32'(off), next_rand());
                run_inst(make_inst(OPC_LOAD, FNC_LW, 5'd15), base, next_rand());
            end
            for (int off = 0; off < 4; off += 2) begin
                run_inst(make_inst(OPC_STORE, FNC_SH, 5'd0), base + 32'(off), next_rand());
                run_inst(make_inst(OPC_LOAD, FNC_LH, 5'd17), base + 32'(off), next_rand());
                run_inst(make_inst(OPC_LOAD, FNC_LHU, 5'd18), base + 32'(off), next_rand());
                run_inst(make_inst(OPC_LOAD, FNC_LW, 5'd19), base, next_rand());
            end
        end

        // stores presented under stall must not reach memory
        run_inst(make_inst(OPC_OP, 3'b000, 5'd12), next_rand(), next_rand());
        repeat (4) begin
            send(make_inst(OPC_STORE, FNC_SW, 5'd0), 32'd0, addrs[0], next_rand(), 1'b1, 1'b1);
        end
        run_inst(make_inst(OPC_LOAD, FNC_LW, 5'd16), addrs[0], next_rand());
        // a held load result must survive loads presented during the stall
        repeat (3) begin
            send(make_inst(OPC_LOAD, FNC_LW, 5'd20), 32'd0, addrs[5], 32'd0, 1'b1, 1'b1);
        end
        run_inst(make_inst(OPC_JAL, 3'b000, 5'd1), next_rand(), next_rand());

        // drain the last expectation
        send(idle, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0);
        send(idle, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/mem_stage_top.sv
// stage3 with its own data RAM; the RAM has DRAM_WORDS words and upper address bits alias
`default_nettype none
`include "stage3_config.svh"

module mem_stage_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] alu_out,
    input  logic [`XLEN-1:0] rs2d,
    input  logic [`XLEN-1:0] inst,
    output logic [`XLEN-1:0] wb_data,
    output logic [4:0]       wb_rd,
    output logic             rwe
);

    // stage to RAM
    logic [`XLEN-1:0] dcache_addr;
    logic [3:0]       dcache_we;
    logic             dcache_re;
    logic [`XLEN-1:0] dcache_din;
    // RAM to stage, one cycle after the request
    logic [`XLEN-1:0] dcache_dout;

    stage3 u_stage3 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .pc          (pc),
        .alu_out     (alu_out),
        .rs2d        (rs2d),
        .inst        (inst),
        .dcache_dout (dcache_dout),
        .dcache_addr (dcache_addr),
        .dcache_we   (dcache_we),
        .dcache_re   (dcache_re),
        .dcache_din  (dcache_din),
        .wb_data     (wb_data),
        .wb_rd       (wb_rd),
        .rwe         (rwe)
    );

    data_ram u_data_ram (
        .clk  (clk),
        .addr (dcache_addr),
        .we   (dcache_we),
        .re   (dcache_re),
        .din  (dcache_din),
        .dout (dcache_dout)
    );

endmodule

`default_nettype wire

// File: source/stage3.sv
// fixed one-cycle latency to writeback; stall holds all state and blocks memory access
`default_nettype none
`include "stage3_config.svh"

module stage3 import stage3_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] alu_out,
    input  logic [`XLEN-1:0] rs2d,
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] dcache_dout,
    output logic [`XLEN-1:0] dcache_addr,
    output logic [3:0]       dcache_we,
    output logic             dcache_re,
    output logic [`XLEN-1:0] dcache_din,
    output logic [`XLEN-1:0] wb_data,
    output logic [4:0]       wb_rd,
    output logic             rwe
);

    logic [3:0]       w_mask;
    logic             re;
    wb_sel_e          wb_sel;
    logic             rwe_d;
    logic [`XLEN-1:0] dout;

    // writeback pipeline register
    logic [`XLEN-1:0] pc4_q;
    logic [`XLEN-1:0] alu_q;
    wb_sel_e          wb_sel_q;
    logic             rwe_q;
    logic [4:0]       rd_q;

    mw_control u_mw_control (
        .opcode (opcode_e'(inst[6:0])),
        .funct3 (funct3_e'(inst[14:12])),
        .w_mask (w_mask),
        .re     (re),
        .wb_sel (wb_sel),
        .rwe    (rwe_d)
    );

    // alu_out is the effective address for loads and stores
    dmem_access u_dmem_access (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .addr        (alu_out),
        .din         (rs2d),
        .re          (re),
        .w_mask      (w_mask),
        .funct3      (funct3_e'(inst[14:12])),
        .dcache_dout (dcache_dout),
        .dcache_addr (dcache_addr),
        .dcache_we   (dcache_we),
        .dcache_re   (dcache_re),
        .dcache_din  (dcache_din),
        .dout        (dout)
    );

    // control part of the stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_sel_q <= SEL_ALU;
            rwe_q    <= 1'b0;
            rd_q     <= 5'd0;
        end else if (!stall) begin
            wb_sel_q <= wb_sel;
            rwe_q    <= rwe_d;
            rd_q     <= inst[11:7];
        end
    end

    // payload part, only meaningful when rwe_q is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc4_q <= pc + `XLEN'd4;
            alu_q <= alu_out;
        end
    end

    // load data is already aligned by dmem_access in this cycle
    always_comb begin
        case (wb_sel_q)
            SEL_PC4: wb_data = pc4_q;
            SEL_MEM: wb_data = dout;
            default: wb_data = alu_q;
        endcase
    end

    assign wb_rd = rd_q;
    assign rwe   = rwe_q;

endmodule

`default_nettype wire

// File: source/data_ram.sv
// address bits above DRAM_AW+1 and bits [1:0] are ignored, so the RAM aliases; no content reset
`default_nettype none
`include "stage3_config.svh"

module data_ram (
    input  logic             clk,
    input  logic [`XLEN-1:0] addr,
    input  logic [3:0]       we,
    input  logic             re,
    input  logic [`XLEN-1:0] din,
    output logic [`XLEN-1:0] dout
);

    logic [`XLEN-1:0]    mem [`DRAM_WORDS];
    logic [`DRAM_AW-1:0] widx;

    // word index from the byte address
    assign widx = addr[`DRAM_AW+1:2];

    // per-byte writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[widx][8*b +: 8] <= din[8*b +: 8];
            end
        end
    end

    // registered read, old contents on a same-cycle write
    // holds its value while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            dout <= mem[widx];
        end
    end

endmodule

`default_nettype wire

// File: source/dmem_access.sv
// request side is combinational; misaligned half/word accesses are not trapped and wrap lanes
`default_nettype none
`include "stage3_config.svh"

module dmem_access import stage3_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] din,
    input  logic             re,
    input  logic [3:0]       w_mask,
    input  funct3_e          funct3,
    input  logic [`XLEN-1:0] dcache_dout,
    output logic [`XLEN-1:0] dcache_addr,
    output logic [3:0]       dcache_we,
    output logic             dcache_re,
    output logic [`XLEN-1:0] dcache_din,
    output logic [`XLEN-1:0] dout
);

    // byte offset and width of the access in flight
    logic [1:0]       off_q;
    funct3_e          f3_q;
    logic [`XLEN-1:0] shifted;

    // RAM is word organized, lane selection is done by the strobes
    assign dcache_addr = {addr[`XLEN-1:2], 2'b00};

    // no access of either kind while the pipe is held
    assign dcache_we = stall ? 4'b0000 : (w_mask << addr[1:0]);
    assign dcache_re = re & ~stall;

    // copy the store byte/half into every lane, strobes pick the right one
    always_comb begin
        case (funct3)
            FNC_SB:  dcache_din = {4{din[7:0]}};
            FNC_SH:  dcache_din = {2{din[15:0]}};
            default: dcache_din = din;
        endcase
    end

    // capture alongside the RAM read register so both line up in the next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            off_q <= 2'b00;
            f3_q  <= FNC_LB;
        end else if (!stall) begin
            off_q <= addr[1:0];
            f3_q  <= funct3;
        end
    end

    // bring the addressed byte/half down to bit 0
    assign shifted = dcache_dout >> {off_q, 3'b000};

    always_comb begin
        case (f3_q)
            FNC_LB:  dout = {{24{shifted[7]}}, shifted[7:0]};
            FNC_LBU: dout = {24'd0, shifted[7:0]};
            FNC_LH:  dout = {{16{shifted[15]}}, shifted[15:0]};
            FNC_LHU: dout = {16'd0, shifted[15:0]};
            // full word, no alignment
            default: dout = dcache_dout;
        endcase
    end

endmodule

`default_nettype wire

// File: source/mw_control.sv
// purely combinational decode; unknown opcodes give no access and no register write
`default_nettype none

module mw_control import stage3_pkg::*; (
    input  opcode_e    opcode,
    input  funct3_e    funct3,
    output logic [3:0] w_mask,
    output logic       re,
    output wb_sel_e    wb_sel,
    output logic       rwe
);

    always_comb begin
        // safe defaults: no access, no writeback
        w_mask = 4'b0000;
        re     = 1'b0;
        wb_sel = SEL_ALU;
        rwe    = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                // load data comes back one cycle later
                re     = 1'b1;
                wb_sel = SEL_MEM;
                rwe    = 1'b1;
            end
            OPC_STORE: begin
                // strobes are unshifted here, dmem_access moves them to the byte lane
                case (funct3)
                    FNC_SB:  w_mask = 4'b0001;
                    FNC_SH:  w_mask = 4'b0011;
                    FNC_SW:  w_mask = 4'b1111;
                    default: w_mask = 4'b0000;
                endcase
            end
            OPC_JAL, OPC_JALR: begin
                // link register gets the return address
                wb_sel = SEL_PC4;
                rwe    = 1'b1;
            end
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                wb_sel = SEL_ALU;
                rwe    = 1'b1;
            end
            default: begin
                // branches and anything undecoded write nothing
                rwe = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/stage3_pkg.sv
// RV32I encodings used by the mem/writeback stage; store funct3 names alias the load codes
`default_nettype none

package stage3_pkg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // load widths, bits [14:12]
    typedef enum logic [2:0] {
        FNC_LB  = 3'b000,
        FNC_LH  = 3'b001,
        FNC_LW  = 3'b010,
        FNC_LBU = 3'b100,
        FNC_LHU = 3'b101
    } funct3_e;

    // store widths reuse the load codes, an enum cannot hold duplicate values
    localparam funct3_e FNC_SB = FNC_LB;
    localparam funct3_e FNC_SH = FNC_LH;
    localparam funct3_e FNC_SW = FNC_LW;

    // writeback source
    typedef enum logic [1:0] {
        SEL_ALU = 2'd0,
        SEL_PC4 = 2'd1,
        SEL_MEM = 2'd2
    } wb_sel_e;

endpackage

`default_nettype wire

// File: source/stage3_config.svh
// sizes for the mem/writeback stage; DRAM_AW must be kept equal to log2(DRAM_WORDS) by hand
`ifndef STAGE3_CONFIG_SVH
`define STAGE3_CONFIG_SVH

// data path and address width of the core
`define XLEN 32

// data RAM depth in 32-bit words
`define DRAM_WORDS 256

// word-address width of the data RAM
// log2 of DRAM_WORDS, byte address bits [DRAM_AW+1:2] select the word
`define DRAM_AW 8

`endif
